/* common/issue_pkg.sv */
// Multiply opcode enum, instruction entry and result types, queue and lane sizes

package issue_pkg;

    import thread_pkg::*;

    // ----------------------------------------
    // Lane and queue sizes
    // ----------------------------------------

    // Push lanes from dispatch
    localparam int is_num_c      = 2;
    // Pop lanes, one multiplier each
    localparam int mult_num_c    = 2;
    // Issue queue depth
    localparam int mult_q_size_c = 8;
    // Queue index and entry count widths
    localparam int q_idx_w_c     = $clog2(mult_q_size_c);
    localparam int q_num_w_c     = $clog2(mult_q_size_c + 1);
    // Multiplier pipe depth
    localparam int mult_lat_c    = 3;
    // Operand and result width
    localparam int data_w_c      = 32;

    // ----------------------------------------
    // Opcodes and payloads
    // ----------------------------------------

    // Low word, or high word by operand signedness
    typedef enum logic [1:0] {
        MUL_LO,
        MUL_HI_SS,
        MUL_HI_UU,
        MUL_HI_SU
    } mult_op_e;

    // Issued instruction, operands already read
    typedef struct packed {
        thread_idx_t         thread;
        tag_t                tag;
        mult_op_e            op;
        logic [data_w_c-1:0] src1;
        logic [data_w_c-1:0] src2;
    } mult_inst_t;

    // Tagged writeback result
    typedef struct packed {
        thread_idx_t         thread;
        tag_t                tag;
        logic [data_w_c-1:0] value;
    } mult_result_t;

endpackage

/* common/thread_pkg.sv */
// Thread count, thread index and squash mask types, reorder tag width and type

package thread_pkg;

    // ----------------------------------------
    // Hardware threads
    // ----------------------------------------

    // Threads sharing the issue stage
    localparam int thread_num_c = 4;

    // Index of one thread
    typedef logic [$clog2(thread_num_c)-1:0] thread_idx_t;

    // One bit per thread, set bits are squashed
    typedef logic [thread_num_c-1:0] thread_mask_t;

    // ----------------------------------------
    // Reorder tags
    // ----------------------------------------

    // Tag naming each instruction in flight
    localparam int tag_w_c = 6;

    typedef logic [tag_w_c-1:0] tag_t;

endpackage

/* issue_buffer/mult_queue.sv */
// Circular multiply issue queue, multi-lane push and pop, thread squash and flush

`timescale 1ns/10ps

module mult_queue import thread_pkg::*, issue_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Push side from dispatch
    input  logic       [is_num_c-1:0]   push_valid_i,
    output logic       [is_num_c-1:0]   push_ready_o,
    input  mult_inst_t [is_num_c-1:0]   push_inst_i,
    // Pop side with lane 0 oldest
    output logic       [mult_num_c-1:0] pop_valid_o,
    input  logic       [mult_num_c-1:0] pop_ready_i,
    output mult_inst_t [mult_num_c-1:0] pop_inst_o,
    // Squash inputs
    input  thread_mask_t                br_mis_i,
    input  logic                        exception_i
);

    // Entry storage and per-entry valid
    mult_inst_t [mult_q_size_c-1:0] queue;
    logic       [mult_q_size_c-1:0] valid;

    // Pointers with wrap bits
    logic [q_idx_w_c-1:0] head;
    logic [q_idx_w_c-1:0] tail;
    logic                 head_wrap;
    logic                 tail_wrap;
    logic [q_num_w_c-1:0] head_sum;
    logic [q_num_w_c-1:0] tail_sum;

    // Occupancy
    logic [q_num_w_c-1:0] data_cnt;
    logic [q_num_w_c-1:0] free_cnt;
    logic [q_num_w_c-1:0] push_cnt;
    logic [q_num_w_c-1:0] pop_cnt;

    // Per-lane handshakes and slots
    logic [is_num_c-1:0]                 push_en;
    logic [is_num_c-1:0][q_idx_w_c-1:0]  push_idx;
    logic [mult_q_size_c-1:0]            push_sel;
    logic [mult_num_c-1:0]               pop_en;
    logic [mult_num_c-1:0]               skip;
    logic [mult_num_c-1:0][q_idx_w_c-1:0] pop_idx;
    logic [mult_q_size_c-1:0]            pop_sel;

    // Slot offset from a pointer modulo depth
    function automatic logic [q_idx_w_c-1:0] wrap_idx(
        input logic [q_idx_w_c-1:0] base,
        input logic [q_num_w_c-1:0] off
    );
        logic [q_num_w_c-1:0] sum;
        sum = q_num_w_c'(base) + off;
        if (sum >= q_num_w_c'(mult_q_size_c)) begin
            sum = sum - q_num_w_c'(mult_q_size_c);
        end
        return sum[q_idx_w_c-1:0];
    endfunction

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------

    always_comb begin
        if (head_wrap == tail_wrap) begin
            data_cnt = q_num_w_c'(tail) - q_num_w_c'(head);
        end else begin
            data_cnt = q_num_w_c'(mult_q_size_c) - q_num_w_c'(head) + q_num_w_c'(tail);
        end
        // Slots leaving this cycle count as free
        free_cnt = q_num_w_c'(mult_q_size_c) - data_cnt + pop_cnt;
    end

    // ----------------------------------------
    // Push lanes
    // ----------------------------------------

    always_comb begin
        push_cnt = '0;
        push_sel = '0;
        for (int k = 0; k < is_num_c; k++) begin
            // Ready in lane order
            push_ready_o[k] = (k < free_cnt);
            push_en[k]      = push_valid_i[k] && push_ready_o[k];
            push_idx[k]     = wrap_idx(tail, q_num_w_c'(k));
            if (push_en[k]) begin
                push_cnt              = push_cnt + 1'b1;
                push_sel[push_idx[k]] = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Pop lanes
    // ----------------------------------------

    always_comb begin
        logic prev_done;
        logic live;
        prev_done = 1'b1;
        pop_cnt   = '0;
        pop_sel   = '0;
        for (int j = 0; j < mult_num_c; j++) begin
            pop_idx[j]    = wrap_idx(head, q_num_w_c'(j));
            pop_inst_o[j] = queue[pop_idx[j]];
            // Dead if cleared earlier or hit by this mispredict
            live = valid[pop_idx[j]] && !br_mis_i[queue[pop_idx[j]].thread];
            // Only move when every older lane leaves too
            pop_valid_o[j] = prev_done && live;
            skip[j]        = prev_done && (j < data_cnt) && !live;
            pop_en[j]      = pop_valid_o[j] && pop_ready_i[j];
            prev_done      = pop_en[j] || skip[j];
            if (prev_done) begin
                pop_cnt             = pop_cnt + 1'b1;
                pop_sel[pop_idx[j]] = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Pointers
    // ----------------------------------------

    assign head_sum = q_num_w_c'(head) + pop_cnt;
    assign tail_sum = q_num_w_c'(tail) + push_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            head      <= '0;
            tail      <= '0;
            head_wrap <= 1'b0;
            tail_wrap <= 1'b0;
        end else begin
            head <= wrap_idx(head, pop_cnt);
            tail <= wrap_idx(tail, push_cnt);
            // Toggle wrap on passing the last slot
            if (head_sum >= q_num_w_c'(mult_q_size_c)) begin
                head_wrap <= ~head_wrap;
            end
            if (tail_sum >= q_num_w_c'(mult_q_size_c)) begin
                tail_wrap <= ~tail_wrap;
            end
        end
    end

    // ----------------------------------------
    // Entries
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            valid <= '0;
        end else begin
            for (int e = 0; e < mult_q_size_c; e++) begin
                if (push_sel[e]) begin
                    valid[e] <= 1'b1;
                end else if (pop_sel[e]) begin
                    valid[e] <= 1'b0;
                end else if (br_mis_i[queue[e].thread]) begin
                    // Slot stays between pointers until skipped at head
                    valid[e] <= 1'b0;
                end
            end
        end
    end

    // Payload write
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < is_num_c; k++) begin
            if (push_en[k]) begin
                queue[push_idx[k]] <= push_inst_i[k];
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Pointer distance stays within depth
    assert property (@(posedge clk_i) disable iff (rst_i)
        data_cnt <= q_num_w_c'(mult_q_size_c));

    // No lane offers past the stored entries
    for (genvar j = 0; j < mult_num_c; j++) begin : g_pop_chk
        assert property (@(posedge clk_i) disable iff (rst_i)
            pop_valid_o[j] |-> (j < data_cnt));
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the multiply issue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_mult_issue \
    -o sim_mult_issue

status=0
./obj_dir/sim_mult_issue > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
exit 0

/* src/mult_issue_top.sv */
// Multiply issue slice top, issue queue feeding two pipelined multiplier lanes

`timescale 1ns/10ps

module mult_issue_top import thread_pkg::*, issue_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // Dispatch push lanes
    input  logic         [is_num_c-1:0]   is_valid_i,
    output logic         [is_num_c-1:0]   is_ready_o,
    input  mult_inst_t   [is_num_c-1:0]   is_inst_i,
    // Squash
    input  thread_mask_t                  br_mis_i,
    input  logic                          exception_i,
    // Writeback lanes
    output logic         [mult_num_c-1:0] wb_valid_o,
    input  logic         [mult_num_c-1:0] wb_ready_i,
    output mult_result_t [mult_num_c-1:0] wb_result_o
);

    // Queue to multiplier lanes
    logic       [mult_num_c-1:0] iss_valid;
    logic       [mult_num_c-1:0] iss_ready;
    mult_inst_t [mult_num_c-1:0] iss_inst;

    // ----------------------------------------
    // Issue queue
    // ----------------------------------------

    mult_queue u_queue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_valid_i (is_valid_i),
        .push_ready_o (is_ready_o),
        .push_inst_i  (is_inst_i),
        .pop_valid_o  (iss_valid),
        .pop_ready_i  (iss_ready),
        .pop_inst_o   (iss_inst),
        .br_mis_i     (br_mis_i),
        .exception_i  (exception_i)
    );

    // ----------------------------------------
    // Multiplier lanes
    // ----------------------------------------

    // Lane 0 takes the oldest entry
    for (genvar m = 0; m < mult_num_c; m++) begin : g_lane
        mult_pipe u_pipe (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .iss_valid_i (iss_valid[m]),
            .iss_ready_o (iss_ready[m]),
            .iss_inst_i  (iss_inst[m]),
            .br_mis_i    (br_mis_i),
            .exception_i (exception_i),
            .res_valid_o (wb_valid_o[m]),
            .res_ready_i (wb_ready_i[m]),
            .res_o       (wb_result_o[m])
        );
    end

endmodule

/* src/mult_pipe.sv */
// Three-stage pipelined multiplier lane with stall, thread squash and tagged result

`timescale 1ns/10ps

module mult_pipe import thread_pkg::*, issue_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    // Issue side
    input  logic         iss_valid_i,
    output logic         iss_ready_o,
    input  mult_inst_t   iss_inst_i,
    // Squash inputs
    input  thread_mask_t br_mis_i,
    input  logic         exception_i,
    // Writeback side
    output logic         res_valid_o,
    input  logic         res_ready_i,
    output mult_result_t res_o
);

    // Stage valids, index 0 is stage 1
    logic [mult_lat_c-1:0] stg_vld;
    logic                  stall;

    // Stage 1, extended operands
    thread_idx_t                s1_thread;
    tag_t                       s1_tag;
    mult_op_e                   s1_op;
    logic signed [data_w_c:0]   s1_a;
    logic signed [data_w_c:0]   s1_b;
    logic signed [2*data_w_c+1:0] prod_full;

    // Stage 2, product
    thread_idx_t             s2_thread;
    tag_t                    s2_tag;
    mult_op_e                s2_op;
    logic [2*data_w_c-1:0]   s2_prod;

    // Stage 3, selected word
    thread_idx_t             s3_thread;
    tag_t                    s3_tag;
    logic [data_w_c-1:0]     s3_val;

    // Per-stage kill
    logic kill_in;
    logic kill_s1;
    logic kill_s2;
    logic kill_s3;

    // ----------------------------------------
    // Flow control
    // ----------------------------------------

    // Held output freezes every stage
    assign stall       = stg_vld[2] && !res_ready_i;
    assign iss_ready_o = !stall;

    assign kill_in = exception_i || br_mis_i[iss_inst_i.thread];
    assign kill_s1 = exception_i || br_mis_i[s1_thread];
    assign kill_s2 = exception_i || br_mis_i[s2_thread];
    assign kill_s3 = exception_i || br_mis_i[s3_thread];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stg_vld <= '0;
        end else if (!stall) begin
            stg_vld[0] <= iss_valid_i && !kill_in;
            stg_vld[1] <= stg_vld[0] && !kill_s1;
            stg_vld[2] <= stg_vld[1] && !kill_s2;
        end else begin
            // Frozen, squash still applies
            stg_vld[0] <= stg_vld[0] && !kill_s1;
            stg_vld[1] <= stg_vld[1] && !kill_s2;
            stg_vld[2] <= stg_vld[2] && !kill_s3;
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    // 33x33 signed covers all signedness mixes
    assign prod_full = s1_a * s1_b;

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            // Stage 1, src1 unsigned only for UU
            s1_thread <= iss_inst_i.thread;
            s1_tag    <= iss_inst_i.tag;
            s1_op     <= iss_inst_i.op;
            s1_a      <= (iss_inst_i.op == MUL_HI_UU) ? {1'b0, iss_inst_i.src1}
                                                      : {iss_inst_i.src1[data_w_c-1],
                                                         iss_inst_i.src1};
            // src2 signed for LO and SS
            s1_b      <= (iss_inst_i.op == MUL_LO || iss_inst_i.op == MUL_HI_SS)
                         ? {iss_inst_i.src2[data_w_c-1], iss_inst_i.src2}
                         : {1'b0, iss_inst_i.src2};
            // Stage 2
            s2_thread <= s1_thread;
            s2_tag    <= s1_tag;
            s2_op     <= s1_op;
            s2_prod   <= prod_full[2*data_w_c-1:0];
            // Stage 3, word select
            s3_thread <= s2_thread;
            s3_tag    <= s2_tag;
            s3_val    <= (s2_op == MUL_LO) ? s2_prod[data_w_c-1:0]
                                           : s2_prod[2*data_w_c-1:data_w_c];
        end
    end

    assign res_valid_o = stg_vld[2];
    assign res_o       = '{thread: s3_thread, tag: s3_tag, value: s3_val};

    // Held result must not change under the consumer
    assert property (@(posedge clk_i) disable iff (rst_i)
        (res_valid_o && !res_ready_i) |=> $stable(res_o));

endmodule

/* verif/tb_mult_tests.svh */
// Directed tests for reset state, arithmetic, back-pressure, branch mispredict, exception, random mix

task automatic test_reset_state();
    start_test("reset");
    @(negedge clk_i);
    if (is_ready_o !== '1 || wb_valid_o !== '0) begin
        err_cnt++;
        $display("%s: ready or writeback valid wrong after reset", cur_test);
    end
    @(posedge clk_i);
    #2;
    end_test();
endtask

// Each op singly over zero, -1 and min signed
task automatic test_arith();
    logic [31:0] corner_v [3];
    mult_inst_t  inst;
    logic [1:0]  acc;
    int          n;
    corner_v[0] = 32'h0000_0000;
    corner_v[1] = 32'hffff_ffff;
    corner_v[2] = 32'h8000_0000;
    n = 0;
    start_test("arith");
    for (int op = 0; op < 4; op++) begin
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                inst = new_inst(thread_idx_t'(n), mult_op_e'(op), corner_v[a], corner_v[b]);
                acc  = '0;
                while (acc[0] !== 1'b1) begin
                    drive_cycle(inst, '0, 2'b01, acc);
                end
                wait_drain(20);
                // Empty queue, no stall
                cmp_count("latency", 4, wb_cyc[inst.tag] - acc_cyc[inst.tag]);
                n++;
            end
        end
    end
    end_test();
endtask

task automatic test_backpressure();
    logic [1:0] acc;
    start_test("backpressure");
    wb_ready_i = '0;
    for (int c = 0; c < 14; c++) begin
        drive_cycle(rand_inst(thread_idx_t'($random(seed))),
                    rand_inst(thread_idx_t'($random(seed))), 2'b11, acc);
    end
    @(negedge clk_i);
    if (is_ready_o !== '0) begin
        err_cnt++;
        $display("%s: is_ready_o still high with writeback held", cur_test);
    end
    @(posedge clk_i);
    #2;
    // Queue depth plus three stages per lane
    cmp_count("accepted", mult_q_size_c + mult_num_c * mult_lat_c, acc_total - acc_base);
    wait_drain(60);
    end_test();
endtask

// Thread 1 squashed while queue and pipes hold work
task automatic test_branch_mis();
    logic [1:0] acc;
    start_test("branch_mis");
    wb_ready_i = '0;
    for (int c = 0; c < 6; c++) begin
        drive_cycle(rand_inst(thread_idx_t'(2 * c)), rand_inst(thread_idx_t'(2 * c + 1)),
                    2'b11, acc);
    end
    pulse_br(4'b0010);
    wb_ready_i = '1;
    for (int c = 0; c < 4; c++) begin
        drive_cycle(rand_inst(thread_idx_t'(c)), rand_inst(2'd1), 2'b11, acc);
    end
    wait_drain(80);
    end_test();
endtask

task automatic test_exception();
    logic [1:0] acc;
    start_test("exception");
    wb_ready_i = '0;
    for (int c = 0; c < 8; c++) begin
        drive_cycle(rand_inst(thread_idx_t'($random(seed))),
                    rand_inst(thread_idx_t'($random(seed))), 2'b11, acc);
    end
    pulse_exc();
    @(negedge clk_i);
    if (is_ready_o !== '1) begin
        err_cnt++;
        $display("%s: is_ready_o not high on both lanes after flush", cur_test);
    end
    @(posedge clk_i);
    #2;
    // Flushed work must stay gone
    wb_ready_i = '1;
    idle(8);
    for (int c = 0; c < 3; c++) begin
        drive_cycle(rand_inst(thread_idx_t'($random(seed))),
                    rand_inst(thread_idx_t'($random(seed))), 2'b11, acc);
    end
    wait_drain(60);
    end_test();
endtask

task automatic test_random();
    logic [1:0] acc;
    logic [1:0] v;
    int         vcnt;
    start_test("random");
    for (int c = 0; c < 200; c++) begin
        vcnt       = {$random(seed)} % 3;
        v          = (vcnt == 0) ? 2'b00 : (vcnt == 1) ? 2'b01 : 2'b11;
        wb_ready_i = 2'($random(seed));
        // Occasional mispredict on a random thread set
        if ({$random(seed)} % 16 == 0) begin
            br_mis_i = thread_mask_t'($random(seed));
        end
        drive_cycle(rand_inst(thread_idx_t'($random(seed))),
                    rand_inst(thread_idx_t'($random(seed))), v, acc);
        br_mis_i = '0;
    end
    wait_drain(100);
    end_test();
endtask

/* verif/tb_mult_issue.sv */
// Multiply issue slice testbench with clock, reset, DUT, scoreboard, compare tasks and watchdog

`timescale 1ns/10ps

module tb_mult_issue import thread_pkg::*, issue_pkg::*; ();

    // Tag space and run budget in cycles
    localparam int tag_num_c     = 2 ** tag_w_c;
    localparam int test_cycles_c = 700;

    logic                          clk_i;
    logic                          rst_i;
    logic         [is_num_c-1:0]   is_valid_i;
    logic         [is_num_c-1:0]   is_ready_o;
    mult_inst_t   [is_num_c-1:0]   is_inst_i;
    thread_mask_t                  br_mis_i;
    logic                          exception_i;
    logic         [mult_num_c-1:0] wb_valid_o;
    logic         [mult_num_c-1:0] wb_ready_i;
    mult_result_t [mult_num_c-1:0] wb_result_o;

    // Scoreboard indexed by tag
    mult_result_t         exp_res [tag_num_c];
    int                   acc_cyc [tag_num_c];
    int                   wb_cyc  [tag_num_c];
    logic [tag_num_c-1:0] pending = '0;
    logic [tag_num_c-1:0] done    = '0;

    // Monitor counters
    int     cyc         = 0;
    int     acc_total   = 0;
    int     mon_chk_cnt = 0;
    int     mon_err_cnt = 0;
    // Test counters
    int     chk_cnt   = 0;
    int     err_cnt   = 0;
    int     test_cnt  = 0;
    int     test_err0 = 0;
    int     acc_base  = 0;
    string  cur_test  = "none";
    integer seed      = 32'h75399638;
    tag_t   next_tag  = '0;

    mult_issue_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .is_valid_i  (is_valid_i),
        .is_ready_o  (is_ready_o),
        .is_inst_i   (is_inst_i),
        .br_mis_i    (br_mis_i),
        .exception_i (exception_i),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_result_o (wb_result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // Reference model and compares
    // ----------------------------------------

    // Expected result from the 64-bit product of extended operands
    function automatic mult_result_t model_result(input mult_inst_t inst);
        logic [63:0]  sa;
        logic [63:0]  ua;
        logic [63:0]  sb;
        logic [63:0]  ub;
        logic [63:0]  prod;
        mult_result_t res;
        sa = {{32{inst.src1[31]}}, inst.src1};
        ua = {32'b0, inst.src1};
        sb = {{32{inst.src2[31]}}, inst.src2};
        ub = {32'b0, inst.src2};
        case (inst.op)
            MUL_LO:    prod = sa * sb;
            MUL_HI_SS: prod = sa * sb;
            MUL_HI_UU: prod = ua * ub;
            default:   prod = sa * ub;
        endcase
        res.thread = inst.thread;
        res.tag    = inst.tag;
        res.value  = (inst.op == MUL_LO) ? prod[31:0] : prod[63:32];
        return res;
    endfunction

    task automatic cmp_result(input mult_result_t exp, input mult_result_t act);
        mon_chk_cnt++;
        if (act !== exp) begin
            mon_err_cnt++;
            $display("ERR %s expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic cmp_count(input string what, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    function automatic int total_errs();
        return err_cnt + mon_err_cnt;
    endfunction

    // ----------------------------------------
    // Monitor
    // ----------------------------------------

    task automatic check_wb(input mult_result_t res);
        if (pending[res.tag]) begin
            cmp_result(exp_res[res.tag], res);
            pending[res.tag] = 1'b0;
            done[res.tag]    = 1'b1;
            wb_cyc[res.tag]  = cyc;
        end else begin
            mon_err_cnt++;
            if (done[res.tag]) begin
                $display("%s: tag %0d was written back twice", cur_test, res.tag);
            end else begin
                $display("%s: tag %0d written back but not in flight", cur_test, res.tag);
            end
        end
    endtask

    // Mid-cycle sample of the handshakes at the coming edge
    always @(negedge clk_i) begin
        if (!rst_i) begin
            for (int m = 0; m < mult_num_c; m++) begin
                if (wb_valid_o[m] && wb_ready_i[m]) begin
                    check_wb(wb_result_o[m]);
                end
            end
            // Squash hits older work only
            for (int t = 0; t < tag_num_c; t++) begin
                if (exception_i || br_mis_i[exp_res[t].thread]) begin
                    pending[t] = 1'b0;
                end
            end
            for (int k = 0; k < is_num_c; k++) begin
                if (is_valid_i[k] && is_ready_o[k]) begin
                    acc_total++;
                    // Push beside an exception is dropped
                    if (!exception_i) begin
                        exp_res[is_inst_i[k].tag] = model_result(is_inst_i[k]);
                        acc_cyc[is_inst_i[k].tag] = cyc;
                        pending[is_inst_i[k].tag] = 1'b1;
                        done[is_inst_i[k].tag]    = 1'b0;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Next tag not still in flight
    function automatic mult_inst_t new_inst(input thread_idx_t thread, input mult_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        mult_inst_t inst;
        while (pending[next_tag]) begin
            next_tag = next_tag + 1'b1;
        end
        inst.thread = thread;
        inst.tag    = next_tag;
        inst.op     = op;
        inst.src1   = a;
        inst.src2   = b;
        next_tag    = next_tag + 1'b1;
        return inst;
    endfunction

    function automatic mult_inst_t rand_inst(input thread_idx_t thread);
        return new_inst(thread, mult_op_e'(2'($random(seed))), $random(seed), $random(seed));
    endfunction

    // One push cycle reporting the accepted lanes
    task automatic drive_cycle(input mult_inst_t i0, input mult_inst_t i1,
                               input logic [1:0] v, output logic [1:0] acc);
        is_inst_i[0] = i0;
        is_inst_i[1] = i1;
        is_valid_i   = v;
        @(negedge clk_i);
        acc = is_valid_i & is_ready_o;
        @(posedge clk_i);
        #2;
        is_valid_i = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic pulse_br(input thread_mask_t mask);
        br_mis_i = mask;
        @(posedge clk_i);
        #2;
        br_mis_i = '0;
    endtask

    task automatic pulse_exc();
        exception_i = 1'b1;
        @(posedge clk_i);
        #2;
        exception_i = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        wb_ready_i = '1;
        while ((pending != '0 || wb_valid_o != '0) && n < limit) begin
            @(posedge clk_i);
            #2;
            n++;
        end
        cmp_count("pending tags", 0, $countones(pending));
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = total_errs();
        acc_base  = acc_total;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %-12s %s, %0d errors", cur_test,
                 (total_errs() == test_err0) ? "ok" : "failed", total_errs() - test_err0);
    endtask

    `include "tb_mult_tests.svh"

    initial begin
        rst_i       = 1'b1;
        is_valid_i  = '0;
        is_inst_i   = '0;
        br_mis_i    = '0;
        exception_i = 1'b0;
        wb_ready_i  = '1;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        test_reset_state();
        test_arith();
        test_backpressure();
        test_branch_mis();
        test_exception();
        test_random();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt,
                 chk_cnt + mon_chk_cnt, total_errs());
        if (total_errs() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog over the run budget times margin
    initial begin
        repeat (test_cycles_c * 40) @(posedge clk_i);
        $display("Timeout: tests did not finish within %0d cycles", test_cycles_c * 40);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
common/thread_pkg.sv
common/issue_pkg.sv
issue_buffer/mult_queue.sv
src/mult_pipe.sv
src/mult_issue_top.sv
verif/tb_mult_issue.sv
